// File: Bender.yml
package:
  name: main_bus

export_include_dirs:
  - .

sources:
  - main_pkg.sv
  - chip_select_decoder.sv
  - analog_shaper.sv
  - cabinet_io.sv
  - data_bus_mux.sv
  - main_bus_top.sv
  - target: test
    files:
      - tb_main_bus.sv

// File: analog_shaper.sv
// ADC channel value for the cabinet analog inputs
// Steering, gas and brake shaping per game and controller type
// Digital buttons override the analog readings

`timescale 1ns/1ps

module analog_shaper (
    input  main_pkg::game_e      game,
    input  main_pkg::ctrl_type_e ctrl_type,
    input  main_pkg::adc_ch_e    adc_ch,
    input  logic [7:0]           joystick,
    input  logic [15:0]          ana_steer,
    input  logic [15:0]          ana_pedal,
    output logic [7:0]           value
);
    import main_pkg::*;

    logic [7:0] pos_half;
    logic [7:0] neg_half;
    logic [7:0] steer_raw;
    logic [7:0] trig_gas;
    logic       pedal_neg;

    // Pedal axis split at its sign bit
    assign pos_half  = {ana_pedal[14:8], ana_pedal[14]};
    assign neg_half  = ~pos_half;
    assign pedal_neg = ana_pedal[15];

    assign steer_raw = ana_steer[7:0] ^ 8'h80;  // Signed to offset binary
    assign trig_gas  = ana_pedal[7] ? 8'h00 : {ana_pedal[6:0], ana_pedal[6]};

    always_comb begin
        value = 8'hFF;  // Motor and unused channels
        if (game == GAME_SHANGON) begin
            case (adc_ch)
                ADC_STEER: value = !joystick[0] ? 8'h20 :
                                   !joystick[1] ? 8'hD0 : steer_raw;
                ADC_GAS:   value = !joystick[3] ? 8'hF0 :
                                   pedal_neg    ? neg_half : 8'h00;
                ADC_BRAKE: value = !joystick[2] ? 8'hF0 :
                                   pedal_neg    ? 8'h00 : pos_half;
                default:   value = 8'hFF;
            endcase
        end else begin
            case (adc_ch)
                // Left button wins when both are held
                ADC_STEER: value = !joystick[1] ? 8'h20 :
                                   !joystick[0] ? 8'hE0 : steer_raw;
                ADC_GAS: begin
                    if (!joystick[5]) begin
                        value = 8'hFF;
                    end else if (ctrl_type == CTRL_TRIGGER) begin
                        value = trig_gas;
                    end else begin
                        value = pedal_neg ? neg_half : 8'h00;
                    end
                end
                ADC_BRAKE: begin
                    if (!joystick[6]) begin
                        value = 8'hFF;
                    end else if (ctrl_type == CTRL_WHEEL) begin
                        value = pedal_neg ? neg_half : 8'h00;  // Wheel pedals are inverted
                    end else begin
                        value = pedal_neg ? 8'h00 : pos_half;
                    end
                end
                default: value = 8'hFF;
            endcase
        end
    end

endmodule

// File: build.f
+incdir+.
main_pkg.sv
chip_select_decoder.sv
analog_shaper.sv
cabinet_io.sv
data_bus_mux.sv
main_bus_top.sv
tb_main_bus.sv

// File: cabinet_io.sv
// Cabinet I/O for both board variants
// Registered read byte, board control latches and analog latch
// Object toggle pulse on the PPI board

`timescale 1ns/1ps
`include "main_params.svh"

module cabinet_io (
    input  logic                  clk,
    input  logic                  rst,
    input  main_pkg::game_e       game,
    input  main_pkg::ctrl_type_e  ctrl_type,
    input  logic                  req_valid,
    input  main_pkg::bus_req_t    req,
    input  main_pkg::cab_in_t     cab,
    output logic [7:0]            io_byte,
    output main_pkg::board_ctrl_t ctrl,
    output logic                  obj_toggle
);
    import main_pkg::*;

    logic        io_hit;
    logic        ppi_board;
    logic        low_wr;
    logic        pc_access;
    logic        adc_wr;
    logic [2:0]  offset;
    logic [1:0]  sw_sel;
    logic [7:0]  port_c;
    logic [7:0]  rd_byte;
    logic [7:0]  adc_value;
    logic [15:0] steer_lat;
    logic [15:0] pedal_lat;

    // Port C byte to control fields
    function automatic board_ctrl_t pc_to_ctrl(input logic [7:0] pc);
        board_ctrl_t c;
        c.obj_cfg  = pc[7:6];
        c.video_en = pc[5];
        c.adc_ch   = adc_ch_e'(pc[4:2]);
        c.snd_rstb = pc[0];
        return c;
    endfunction

    assign io_hit    = req_valid && req.active[`REG_IO] && (req.fc != `FC_IACK);
    assign ppi_board = (game == GAME_OUTRUN);
    assign low_wr    = !req.rnw && !req.dsn[0];
    assign offset    = ppi_board ? req.addr[6:4] : {req.addr[13:12], req.addr[5]};
    assign sw_sel    = req.addr[2:1];
    assign pc_access = ppi_board && (offset == 3'd0) && (sw_sel == 2'd2);
    assign adc_wr    = io_hit && !req.rnw && (offset == (ppi_board ? 3'd3 : 3'd7));

    analog_shaper analog_shaper_i (
        .game      (game),
        .ctrl_type (ctrl_type),
        .adc_ch    (ctrl.adc_ch),
        .joystick  (cab.joystick),
        .ana_steer (steer_lat),
        .ana_pedal (pedal_lat),
        .value     (adc_value)
    );

    always_comb begin
        rd_byte = `FILL_BYTE;
        if (pc_access) begin
            rd_byte = port_c;
        end else if (ppi_board) begin
            case (offset)
                3'd1: case (sw_sel)
                    2'd0:    rd_byte = {cab.coin, ~cab.joystick[7], cab.joystick[7],
                                        cab.start, cab.service, cab.dip_test, 1'b1};
                    2'd2:    rd_byte = cab.dipsw_a;
                    2'd3:    rd_byte = cab.dipsw_b;
                    default: rd_byte = `FILL_BYTE;
                endcase
                3'd3:    rd_byte = adc_value;
                default: rd_byte = `FILL_BYTE;
            endcase
        end else begin
            case (offset)
                3'd2: case (sw_sel)
                    2'd1:    rd_byte = {2'b11, cab.joystick[4], cab.start, cab.service,
                                        cab.dip_test, cab.coin};
                    2'd2:    rd_byte = cab.dipsw_a;
                    2'd3:    rd_byte = cab.dipsw_b;
                    default: rd_byte = `FILL_BYTE;
                endcase
                3'd7:    rd_byte = adc_value;
                default: rd_byte = `FILL_BYTE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        io_byte <= io_hit ? rd_byte : `FILL_BYTE;
        if (adc_wr) begin   // Sample both axes for later ADC reads
            steer_lat <= cab.ana_steer;
            pedal_lat <= cab.ana_pedal;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port_c     <= `CTRL_RESET;
            ctrl       <= pc_to_ctrl(`CTRL_RESET);
            obj_toggle <= 1'b0;
        end else begin
            obj_toggle <= io_hit && ppi_board && (offset == 3'd7);
            if (io_hit && low_wr) begin
                if (pc_access) begin
                    port_c <= req.wdata[7:0];
                    ctrl   <= pc_to_ctrl(req.wdata[7:0]);
                end else if (!ppi_board) begin
                    case (offset)
                        3'd0: begin
                            ctrl.adc_ch   <= adc_ch_e'({1'b0, req.wdata[7:6]});
                            ctrl.video_en <= req.wdata[4];
                        end
                        3'd1:    ctrl.snd_rstb <= ~req.wdata[0];  // Bit set holds reset
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

// File: chip_select_decoder.sv
// Chip select decoder for the main CPU bus
// Registers one cycle of selects per request strobe

`timescale 1ns/1ps
`include "main_params.svh"

module chip_select_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  main_pkg::bus_req_t   req,
    output main_pkg::chip_sel_t  cs
);

    logic decode_en;
    logic any_ds;       // At least one data strobe low
    logic mem_hi;       // Work RAM window of the memory region

    assign decode_en = req_valid && (req.fc != `FC_IACK);
    assign any_ds    = ~&req.dsn;
    assign mem_hi    = &req.addr[18:17];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs <= '0;
        end else if (decode_en) begin
            cs.rd   <= req.rnw;
            cs.rom  <= req.active[`REG_MEM] && !mem_hi;
            cs.ram  <= req.active[`REG_MEM] && mem_hi && any_ds;

            // Scroll region splits into character RAM and VRAM
            cs.chr  <= req.active[`REG_SCR] &&  req.addr[16];
            cs.vram <= req.active[`REG_SCR] && !req.addr[16] && any_ds;

            cs.pal  <= req.active[`REG_PAL];
            cs.obj  <= req.active[`REG_OBJ];
            cs.io   <= req.active[`REG_IO];
            cs.sub  <= req.active[`REG_SUB];
        end else begin
            cs <= '0;   // Selects last a single cycle
        end
    end

endmodule

// File: data_bus_mux.sv
// Read data multiplexer for the main CPU
// Priority select of memory and I/O data into a registered word

`timescale 1ns/1ps
`include "main_params.svh"

module data_bus_mux (
    input  logic                 clk,
    input  logic                 rst,
    input  main_pkg::chip_sel_t  cs,
    input  logic [7:0]           io_byte,
    input  main_pkg::mem_rdata_t mem,
    output logic [`DATA_W-1:0]   rdata,
    output logic                 rdata_valid
);

    logic [`DATA_W-1:0] sel_word;

    // First match wins
    always_comb begin
        if (cs.ram || cs.vram) begin
            sel_word = mem.ram;
        end else if (cs.rom) begin
            sel_word = mem.rom;     // Raw ROM data, no decryption
        end else if (cs.chr) begin
            sel_word = mem.chr;
        end else if (cs.pal) begin
            sel_word = mem.pal;
        end else if (cs.obj) begin
            sel_word = mem.obj;
        end else if (cs.sub) begin
            sel_word = mem.sub;
        end else if (cs.io) begin
            sel_word = {`FILL_BYTE, io_byte};   // Byte wide port on the low lane
        end else begin
            sel_word = {2{`FILL_BYTE}};
        end
    end

    always_ff @(posedge clk) begin
        rdata <= sel_word;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= cs.rd;
        end
    end

endmodule

// File: main_bus_top.sv
// Top level of the main board bus glue
// Chip select decoder and cabinet I/O side by side, read mux behind them

`timescale 1ns/1ps
`include "main_params.svh"

module main_bus_top (
    input  logic                  clk,
    input  logic                  rst,
    input  main_pkg::game_e       game,
    input  main_pkg::ctrl_type_e  ctrl_type,
    input  logic                  req_valid,
    input  main_pkg::bus_req_t    req,
    input  main_pkg::mem_rdata_t  mem,
    input  main_pkg::cab_in_t     cab,
    output main_pkg::chip_sel_t   cs_out,
    output logic [`DATA_W-1:0]    rdata,
    output logic                  rdata_valid,
    output main_pkg::board_ctrl_t ctrl,
    output logic                  obj_toggle
);

    logic [7:0] io_byte;    // Cabinet byte, valid with the selects

    chip_select_decoder chip_select_decoder_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .cs        (cs_out)
    );

    // Same strobe as the decoder
    cabinet_io cabinet_io_i (
        .clk        (clk),
        .rst        (rst),
        .game       (game),
        .ctrl_type  (ctrl_type),
        .req_valid  (req_valid),
        .req        (req),
        .cab        (cab),
        .io_byte    (io_byte),
        .ctrl       (ctrl),
        .obj_toggle (obj_toggle)
    );

    data_bus_mux data_bus_mux_i (
        .clk         (clk),
        .rst         (rst),
        .cs          (cs_out),
        .io_byte     (io_byte),
        .mem         (mem),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

endmodule

// File: main_params.svh
// Widths, region indices and fill values for the main board glue
// Included by the package and by the modules that decode the bus

`ifndef MAIN_PARAMS_SVH
`define MAIN_PARAMS_SVH

// Bus widths
`define ADDR_W      23      // Word address, byte bits 23:1
`define DATA_W      16
`define REGION_W    8       // Region active bits from the mapper

// Region indices into the active bits
`define REG_MEM     0
`define REG_SCR     1
`define REG_PAL     2
`define REG_OBJ     3
`define REG_IO      4
`define REG_SUB     5

// Interrupt acknowledge cycles never select a device
`define FC_IACK     3'd7

// Unmapped bytes read back as all ones
`define FILL_BYTE   8'hFF

// Control byte in port C layout
// Video on, sound out of reset, ADC channel 0, object config 0
`define CTRL_RESET  8'h21

`endif

// File: main_pkg.sv
// Shared types for the main board glue
// Game, controller and ADC channel enums
// Bus request, chip select, memory read data, cabinet and control structs

`include "main_params.svh"

package main_pkg;

    // OutRun uses the PPI board, Super Hang-On the direct registers
    typedef enum logic {
        GAME_OUTRUN  = 1'b0,
        GAME_SHANGON = 1'b1
    } game_e;

    typedef enum logic [1:0] {
        CTRL_STICK   = 2'd0,
        CTRL_TRIGGER = 2'd1,
        CTRL_WHEEL   = 2'd2
    } ctrl_type_e;

    typedef enum logic [2:0] {
        ADC_STEER = 3'd0,
        ADC_GAS   = 3'd1,
        ADC_BRAKE = 3'd2,
        ADC_MOTOR = 3'd3
    } adc_ch_e;

    typedef struct packed {
        logic [`ADDR_W:1]     addr;     // Byte address numbering, bit 0 dropped
        logic [2:0]           fc;
        logic                 rnw;
        logic [1:0]           dsn;      // Upper, lower; active low
        logic [`DATA_W-1:0]   wdata;
        logic [`REGION_W-1:0] active;
    } bus_req_t;

    typedef struct packed {
        logic rd, rom, ram, vram, chr, pal, obj, io, sub;
    } chip_sel_t;

    typedef struct packed {
        logic [`DATA_W-1:0] ram;        // Shared by work RAM and VRAM
        logic [`DATA_W-1:0] rom;
        logic [`DATA_W-1:0] chr;
        logic [`DATA_W-1:0] pal;
        logic [`DATA_W-1:0] obj;
        logic [`DATA_W-1:0] sub;
    } mem_rdata_t;

    typedef struct packed {
        logic [7:0]  joystick;          // Active low buttons
        logic        start;
        logic        service;
        logic        dip_test;
        logic [1:0]  coin;
        logic [7:0]  dipsw_a;
        logic [7:0]  dipsw_b;
        logic [15:0] ana_steer;
        logic [15:0] ana_pedal;         // Gas and brake share one axis
    } cab_in_t;

    typedef struct packed {
        logic [1:0] obj_cfg;
        logic       video_en;
        logic       snd_rstb;
        adc_ch_e    adc_ch;
    } board_ctrl_t;

endpackage

// File: tb_main_bus.sv
// Testbench for the main board bus glue
// Clock, reset, directed and random stimulus, reference model, checks, watchdog

`timescale 1ns/1ps
`include "main_params.svh"

module tb_main_bus;
    import main_pkg::*;

    localparam int MAX_REQ = 5000;  // Bound on requests over all six runs

    logic clk = 1'b0;
    logic rst, req_valid, rdata_valid, obj_toggle;
    logic [`DATA_W-1:0] rdata;
    game_e game;
    ctrl_type_e ctrl_type;
    bus_req_t req;
    mem_rdata_t mem;
    cab_in_t cab;
    chip_sel_t cs_out;
    board_ctrl_t ctrl, m_ctrl, exp_ctrl;
    int cyc = 0;
    int n_cs = 0;
    int n_rd = 0;
    int n_ctl = 0;
    bit checking = 0;
    string tname = "reset";
    logic [7:0] m_portc;
    logic [15:0] m_steer, m_pedal;
    // Expected results, each with the cycle it is due
    int cs_t[$], rd_t[$], ct_t[$], tg_t[$];
    chip_sel_t cs_v[$];
    logic [15:0] rd_v[$];
    board_ctrl_t ct_v[$];

    main_bus_top main_bus_top_i (.*);

    always #4 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    function automatic board_ctrl_t ctrl_from_byte(input logic [7:0] b);
        return {b[7:6], b[5], b[0], b[4:2]};   // obj_cfg, video, sound, channel
    endfunction

    function automatic chip_sel_t model_cs(input bus_req_t r);
        chip_sel_t c;
        logic hi, ds;
        c = '0;
        hi = r.addr[18] & r.addr[17];
        ds = (r.dsn != 2'b11);
        if (r.fc != 3'd7) begin
            c = {r.rnw, r.active[0] & ~hi, r.active[0] & hi & ds,
                 r.active[1] & ~r.addr[16] & ds, r.active[1] & r.addr[16],
                 r.active[2], r.active[3], r.active[4], r.active[5]};
        end
        return c;
    endfunction

    function automatic logic [7:0] model_adc(input logic [2:0] ch, input logic [7:0] joy);
        logic [7:0] pos, steer;
        logic neg;
        pos = {m_pedal[14:8], m_pedal[14]};
        neg = m_pedal[15];
        steer = {~m_steer[7], m_steer[6:0]};
        if (game == GAME_SHANGON) begin
            case (ch)
                3'd0: return !joy[0] ? 8'h20 : (!joy[1] ? 8'hD0 : steer);
                3'd1: return !joy[3] ? 8'hF0 : (neg ? ~pos : 8'h00);
                3'd2: return !joy[2] ? 8'hF0 : (neg ? 8'h00 : pos);
                default: return 8'hFF;
            endcase
        end
        case (ch)
            3'd0: return !joy[1] ? 8'h20 : (!joy[0] ? 8'hE0 : steer);
            3'd1: if (!joy[5]) return 8'hFF;
                  else if (ctrl_type == CTRL_TRIGGER)
                      return m_pedal[7] ? 8'h00 : {m_pedal[6:0], m_pedal[6]};
                  else return neg ? ~pos : 8'h00;
            3'd2: if (!joy[6]) return 8'hFF;
                  else if (ctrl_type == CTRL_WHEEL) return neg ? ~pos : 8'h00;
                  else return neg ? 8'h00 : pos;
            default: return 8'hFF;
        endcase
    endfunction

    // Predicts every result of one request, then drives it for one cycle
    task automatic issue(input bus_req_t r);
        chip_sel_t c;
        logic [7:0] b;
        logic [15:0] w;
        logic ppi;
        logic [2:0] off;
        logic [1:0] sel;
        c = model_cs(r);
        ppi = (game == GAME_OUTRUN);
        off = ppi ? r.addr[6:4] : {r.addr[13:12], r.addr[5]};
        sel = r.addr[2:1];
        b = 8'hFF;
        if (ppi && off == 3'd0 && sel == 2'd2) b = m_portc;
        else if (ppi && off == 3'd1 && sel != 2'd1)
            b = (sel == 2'd0) ? {cab.coin, ~cab.joystick[7], cab.joystick[7], cab.start,
                                 cab.service, cab.dip_test, 1'b1}
                              : (sel == 2'd2 ? cab.dipsw_a : cab.dipsw_b);
        else if (!ppi && off == 3'd2 && sel != 2'd0)
            b = (sel == 2'd1) ? {2'b11, cab.joystick[4], cab.start, cab.service,
                                 cab.dip_test, cab.coin}
                              : (sel == 2'd2 ? cab.dipsw_a : cab.dipsw_b);
        else if (off == (ppi ? 3'd3 : 3'd7)) b = model_adc(m_ctrl.adc_ch, cab.joystick);
        // Read word priority
        if (c.ram || c.vram) w = mem.ram;
        else if (c.rom) w = mem.rom;
        else if (c.chr) w = mem.chr;
        else if (c.pal) w = mem.pal;
        else if (c.obj) w = mem.obj;
        else if (c.sub) w = mem.sub;
        else if (c.io) w = {8'hFF, b};
        else w = 16'hFFFF;
        cs_t.push_back(cyc + 1);
        cs_v.push_back(c);
        if (c.rd) begin
            rd_t.push_back(cyc + 2);
            rd_v.push_back(w);
        end
        if (c.io) begin
            if (ppi && off == 3'd7) tg_t.push_back(cyc + 1);
            if (!r.rnw && off == (ppi ? 3'd3 : 3'd7)) begin
                m_steer = cab.ana_steer;
                m_pedal = cab.ana_pedal;
            end
            if (!r.rnw && !r.dsn[0] && (ppi ? (off == 3'd0 && sel == 2'd2) : off < 3'd2)) begin
                if (ppi) begin
                    m_portc = r.wdata[7:0];
                    m_ctrl = ctrl_from_byte(m_portc);
                end else if (off == 3'd0) begin
                    m_ctrl.adc_ch = adc_ch_e'({1'b0, r.wdata[7:6]});
                    m_ctrl.video_en = r.wdata[4];
                end else begin
                    m_ctrl.snd_rstb = ~r.wdata[0];
                end
                ct_t.push_back(cyc + 1);
                ct_v.push_back(m_ctrl);
            end
        end
        req = r;
        req_valid = 1'b1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    function automatic bus_req_t io_req(input logic rnw, input logic [2:0] off,
                                        input logic [1:0] sel, input logic [15:0] wd);
        bus_req_t r;
        logic [63:0] rnd;
        rnd = {$urandom, $urandom};
        r = rnd[$bits(bus_req_t)-1:0];
        if (game == GAME_OUTRUN) r.addr[6:4] = off;
        else {r.addr[13:12], r.addr[5]} = off;
        r.addr[2:1] = sel;
        r.fc = 3'd5;
        r.rnw = rnw;
        r.dsn = 2'b00;
        r.wdata = wd;
        r.active = 8'h1 << `REG_IO;
        return r;
    endfunction

    always @(negedge clk) begin : check_outputs
        chip_sel_t e_cs;
        logic e_rv, e_tg;
        e_cs = '0;
        e_rv = 1'b0;
        e_tg = 1'b0;
        if (checking) begin
            if (cs_t.size() > 0 && cs_t[0] == cyc) begin
                void'(cs_t.pop_front());
                e_cs = cs_v.pop_front();
            end
            if (ct_t.size() > 0 && ct_t[0] == cyc) begin
                void'(ct_t.pop_front());
                exp_ctrl = ct_v.pop_front();
            end
            if (tg_t.size() > 0 && tg_t[0] == cyc) e_tg = tg_t.pop_front() >= 0;
            assert (cs_out === e_cs) else begin
                n_cs++;
                $display("[ERROR] %s cs_out expected %h actual %h", tname, e_cs, cs_out);
            end
            if (rd_t.size() > 0 && rd_t[0] == cyc) begin
                void'(rd_t.pop_front());
                e_rv = 1'b1;
                assert (rdata === rd_v[0]) else begin
                    n_rd++;
                    $display("[ERROR] %s rdata expected %h actual %h", tname, rd_v[0], rdata);
                end
                void'(rd_v.pop_front());
            end
            assert (rdata_valid === e_rv) else begin
                n_rd++;
                $display("[ERROR] %s rdata_valid expected %b actual %b", tname, e_rv, rdata_valid);
            end
            assert (ctrl === exp_ctrl && obj_toggle === e_tg) else begin
                n_ctl++;
                $display("[ERROR] %s ctrl/toggle expected %h/%b actual %h/%b",
                         tname, exp_ctrl, e_tg, ctrl, obj_toggle);
            end
        end
    end

    task automatic run_game(input game_e g, input ctrl_type_e t);
        logic [63:0] rnd;
        checking = 0;
        rst = 1'b1;
        game = g;
        ctrl_type = t;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        m_portc = `CTRL_RESET;
        m_ctrl = ctrl_from_byte(`CTRL_RESET);
        exp_ctrl = m_ctrl;
        mem = {$urandom, $urandom, $urandom};
        @(negedge clk);
        assert (cs_out === '0 && !rdata_valid && !obj_toggle && ctrl === exp_ctrl) else begin
            n_ctl++;
            $display("Outputs after reset do not hold their reset values");
        end
        @(posedge clk);
        #1;
        checking = 1;
        tname = "analog";
        for (int k = 0; k < 4; k++) begin
            rnd = {$urandom, $urandom};
            cab = rnd[$bits(cab_in_t)-1:0];
            cab.joystick = 8'hFF;
            cab.ana_pedal[15] = k[0];
            cab.ana_pedal[7] = k[1];
            issue(io_req(1'b0, (g == GAME_OUTRUN) ? 3'd3 : 3'd7, 2'd0, 16'($urandom)));
            for (int ch = 0; ch < 4; ch++) begin
                if (g == GAME_OUTRUN) issue(io_req(1'b0, 3'd0, 2'd2, 16'({ch[2:0], 2'b01})));
                else issue(io_req(1'b0, 3'd0, 2'd0, 16'({ch[1:0], 6'h10})));
                for (int bt = 0; bt < 9; bt++) begin
                    cab.joystick = ~(8'h1 << bt);   // Last pass has no button held
                    issue(io_req(1'b1, (g == GAME_OUTRUN) ? 3'd3 : 3'd7, 2'd0, 16'h0));
                end
            end
        end
        tname = "switch";
        for (int k = 0; k < 4; k++) begin
            rnd = {$urandom, $urandom};
            cab = rnd[$bits(cab_in_t)-1:0];
            for (int a = 0; a < 32; a++) issue(io_req(1'b1, a[4:2], a[1:0], 16'h0));
        end
        tname = "control";
        for (int k = 0; k < 40; k++) begin
            req = io_req(1'b0, 3'($urandom), 2'($urandom), 16'($urandom));
            req.dsn = 2'($urandom);
            req.rnw = ($urandom % 4 == 0);
            issue(req);
            if (k % 8 == 0) issue(io_req(k[3], 3'd7, 2'($urandom), 16'h0));
        end
        tname = "random";
        for (int k = 0; k < 300; k++) begin
            if (k % 50 == 0) begin
                repeat (4) @(posedge clk);
                #1;
                mem = {$urandom, $urandom, $urandom};
            end
            rnd = {$urandom, $urandom};
            cab = rnd[$bits(cab_in_t)-1:0];
            rnd = {$urandom, $urandom};
            req = rnd[$bits(bus_req_t)-1:0];
            req.fc = ($urandom % 8 == 0) ? 3'd7 : 3'($urandom % 7);
            req.active = ($urandom % 4 == 0) ? 8'($urandom) : 8'h1 << ($urandom % 6);
            issue(req);
            if ($urandom % 4 == 0) begin
                @(posedge clk);
                #1;
            end
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    initial begin
        #((MAX_REQ * 4 + 500) * 8);
        $display("Watchdog expired before the test sequence completed");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hd064938a));
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        mem = '0;
        cab = '0;
        game = GAME_OUTRUN;
        ctrl_type = CTRL_STICK;
        #1;
        for (int g = 0; g < 2; g++) begin
            for (int t = 0; t < 3; t++) run_game(game_e'(g), ctrl_type_e'(t));
        end
        if (cs_t.size() + rd_t.size() + ct_t.size() + tg_t.size() != 0) begin
            n_ctl++;
            $display("Some expected results were never checked");
        end
        $display("Errors: cs %0d, read %0d, ctrl %0d", n_cs, n_rd, n_ctl);
        if (n_cs + n_rd + n_ctl == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
